/* Makefile */
TOP = memSubsystem_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" sim.log || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* common/memPkg.sv */
package memPkg;

    // byte address on the fetch, cache and load/store ports
    typedef logic [31:0] addrT;

    // instruction or data word
    typedef logic [31:0] wordT;

    // one RAM location
    typedef logic [7:0] byteT;

    // transfer length in bytes, legal values 1, 2 and 4
    typedef logic [2:0] lenT;

    // every fetch moves a whole word
    localparam lenT WordLen = 3'd4;

    // memory controller FSM
    typedef enum logic {
        ctrlIdle,
        ctrlBusy
    } ctrlStateT;

    // owner of the transfer in progress
    typedef enum logic {
        portInst,
        portLs
    } portT;

    // instruction cache miss FSM
    typedef enum logic {
        cacheIdle,
        cacheWait
    } cacheStateT;

endpackage

/* icache/instCache.sv */
`timescale 1ns/100ps

module instCache #(
    parameter int CacheIndexWidth = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         redirect,
    input  logic         fetchReq,
    input  memPkg::addrT fetchPc,
    output logic         hitValid,
    output memPkg::wordT hitInst,
    output logic         fetchEn,
    output memPkg::addrT fetchAddr,
    input  logic         instOutEn,
    input  memPkg::wordT fillInst,
    input  memPkg::addrT fillAddr
);

    localparam int NumLines = 2 ** CacheIndexWidth;
    // word aligned, so the two low address bits are not stored
    localparam int TagWidth = 30 - CacheIndexWidth;

    memPkg::cacheStateT state;

    logic [NumLines-1:0] lineValid;
    logic [TagWidth-1:0] lineTag [NumLines];
    memPkg::wordT        lineData [NumLines];

    logic [CacheIndexWidth-1:0] reqIdx;
    logic [CacheIndexWidth-1:0] fillIdx;
    logic [TagWidth-1:0]        reqTag;
    logic [TagWidth-1:0]        fillTag;
    logic                       lookupHit;
    logic                       fillMatch;
    logic                       hitValidQ;
    logic                       fetchEnQ;

    assign reqIdx = fetchPc[CacheIndexWidth+1:2];
    assign reqTag = fetchPc[31:CacheIndexWidth+2];
    assign fillIdx = fillAddr[CacheIndexWidth+1:2];
    assign fillTag = fillAddr[31:CacheIndexWidth+2];

    assign lookupHit = lineValid[reqIdx] && (lineTag[reqIdx] == reqTag);
    // fetchAddr holds the missing address for the whole wait
    assign fillMatch = instOutEn && (fillAddr == fetchAddr);

    assign hitValid = hitValidQ && rdy;
    assign fetchEn = fetchEnQ && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::cacheIdle;
            lineValid <= '0;
            hitValidQ <= 1'b0;
            fetchEnQ <= 1'b0;
        end else if (rdy) begin
            hitValidQ <= 1'b0;
            fetchEnQ <= 1'b0;
            // fills are kept even when nobody waits for them
            if (instOutEn) begin
                lineValid[fillIdx] <= 1'b1;
            end
            if (redirect) begin
                state <= memPkg::cacheIdle;
            end else begin
                case (state)
                    memPkg::cacheIdle: begin
                        // skip the request that is being answered right now
                        if (fetchReq && !hitValidQ) begin
                            if (lookupHit) begin
                                hitValidQ <= 1'b1;
                            end else begin
                                fetchEnQ <= 1'b1;
                                state <= memPkg::cacheWait;
                            end
                        end
                    end
                    memPkg::cacheWait: begin
                        if (fillMatch) begin
                            hitValidQ <= 1'b1;
                            state <= memPkg::cacheIdle;
                        end
                    end
                    default: state <= memPkg::cacheIdle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (instOutEn) begin
                lineTag[fillIdx] <= fillTag;
                lineData[fillIdx] <= fillInst;
            end
            if (state == memPkg::cacheIdle) begin
                fetchAddr <= fetchPc;
                hitInst <= lineData[reqIdx];
            end else if (fillMatch) begin
                hitInst <= fillInst;
            end
        end
    end

endmodule

/* memCtrl/memCtrl.sv */
`timescale 1ns/100ps

module memCtrl #(
    parameter int RamAddrWidth = 12
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rdy,
    // fetch side
    input  logic                    fetchEn,
    input  memPkg::addrT            fetchAddr,
    input  logic                    misTaken,
    output logic                    instOutEn,
    output memPkg::wordT            inst,
    output memPkg::addrT            addAddr,
    // load/store side
    input  logic                    lsEn,
    input  logic                    lsWrite,
    input  memPkg::addrT            lsAddr,
    input  memPkg::lenT             lsLen,
    input  memPkg::wordT            storeData,
    output logic                    lsDone,
    output memPkg::wordT            ldData,
    // RAM side
    output logic                    ramWrite,
    output logic [RamAddrWidth-1:0] ramAddr,
    output memPkg::byteT            ramWrData,
    input  memPkg::byteT            ramRdData
);

    memPkg::ctrlStateT state;
    memPkg::portT      owner;
    memPkg::lenT       stage;
    memPkg::lenT       curLen;
    logic              curWrite;
    memPkg::addrT      curAddr;
    memPkg::addrT      curBase;
    memPkg::wordT      curData;
    logic              instOutEnQ;
    logic              lsDoneQ;

    // one waiting slot per port
    logic              waitLs;
    logic              waitLsWrite;
    memPkg::addrT      waitLsAddr;
    memPkg::lenT       waitLsLen;
    memPkg::wordT      waitLsData;
    logic              waitInst;
    memPkg::addrT      waitInstAddr;

    logic              lastStage;
    logic              canAccept;
    logic              start;
    memPkg::portT      nextPort;
    logic              nextWrite;
    memPkg::addrT      nextAddr;
    memPkg::lenT       nextLen;
    memPkg::wordT      nextData;
    logic [1:0]        rdIdx;

    // a redirect cuts a fetch short
    assign lastStage = (state == memPkg::ctrlBusy) &&
        ((stage == curLen) || (owner == memPkg::portInst && misTaken));
    assign canAccept = (state == memPkg::ctrlIdle) || lastStage;

    // waiting ls, waiting fetch, new ls, new fetch
    always_comb begin
        start = 1'b1;
        nextPort = memPkg::portLs;
        nextWrite = lsWrite;
        nextAddr = lsAddr;
        nextLen = lsLen;
        nextData = storeData;
        if (waitLs) begin
            nextWrite = waitLsWrite;
            nextAddr = waitLsAddr;
            nextLen = waitLsLen;
            nextData = waitLsData;
        end else if (waitInst && !misTaken) begin
            nextPort = memPkg::portInst;
            nextWrite = 1'b0;
            nextAddr = waitInstAddr;
            nextLen = memPkg::WordLen;
            nextData = '0;
        end else if (!lsEn) begin
            nextPort = memPkg::portInst;
            nextWrite = 1'b0;
            nextAddr = fetchAddr;
            nextLen = memPkg::WordLen;
            nextData = '0;
            start = fetchEn && !misTaken;
        end
    end

    // read data lags the address by one stage
    assign rdIdx = stage[1:0] - 2'd1;

    assign ramWrite = rdy && (state == memPkg::ctrlBusy) && curWrite && (stage < curLen);
    // while stalled, the read port stays on the byte of the previous stage
    assign ramAddr = rdy ? curAddr[RamAddrWidth-1:0] : curAddr[RamAddrWidth-1:0] - 1'b1;
    // store bytes go out low byte first
    assign ramWrData = curData[{stage[1:0], 3'b000} +: 8];

    assign instOutEn = instOutEnQ && rdy;
    assign lsDone = lsDoneQ && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::ctrlIdle;
            owner <= memPkg::portInst;
            stage <= '0;
            waitLs <= 1'b0;
            waitInst <= 1'b0;
            instOutEnQ <= 1'b0;
            lsDoneQ <= 1'b0;
        end else if (rdy) begin
            instOutEnQ <= 1'b0;
            lsDoneQ <= 1'b0;
            if (lsEn) begin
                waitLs <= 1'b1;
            end
            if (fetchEn && !misTaken) begin
                waitInst <= 1'b1;
            end
            if (misTaken) begin
                waitInst <= 1'b0;
            end
            if (state == memPkg::ctrlBusy && !lastStage) begin
                stage <= stage + 3'd1;
            end
            if (lastStage) begin
                instOutEnQ <= (owner == memPkg::portInst) && !misTaken;
                lsDoneQ <= owner == memPkg::portLs;
            end
            if (canAccept) begin
                if (start) begin
                    state <= memPkg::ctrlBusy;
                    owner <= nextPort;
                    stage <= '0;
                    if (nextPort == memPkg::portLs) begin
                        waitLs <= 1'b0;
                    end else begin
                        waitInst <= 1'b0;
                    end
                end else begin
                    state <= memPkg::ctrlIdle;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (lsEn) begin
                waitLsWrite <= lsWrite;
                waitLsAddr <= lsAddr;
                waitLsLen <= lsLen;
                waitLsData <= storeData;
            end
            if (fetchEn) begin
                waitInstAddr <= fetchAddr;
            end
            if (state == memPkg::ctrlBusy) begin
                curAddr <= curAddr + 32'd1;
                // little-endian assembly, byte stage-1 arrives now
                if (stage != '0 && !curWrite) begin
                    if (owner == memPkg::portInst) begin
                        inst[{rdIdx, 3'b000} +: 8] <= ramRdData;
                    end else begin
                        ldData[{rdIdx, 3'b000} +: 8] <= ramRdData;
                    end
                end
                if (lastStage && owner == memPkg::portInst) begin
                    addAddr <= curBase;
                end
            end
            if (canAccept && start) begin
                curAddr <= nextAddr;
                curBase <= nextAddr;
                curLen <= nextLen;
                curWrite <= nextWrite;
                curData <= nextData;
                // short loads leave the upper bytes zero
                if (nextPort == memPkg::portLs && !nextWrite) begin
                    ldData <= '0;
                end
            end
        end
    end

endmodule

/* rtl/byteRam.sv */
`timescale 1ns/100ps

module byteRam #(
    parameter int RamAddrWidth = 12
) (
    input  logic                    clk,
    input  logic                    write,
    input  logic [RamAddrWidth-1:0] addr,
    input  memPkg::byteT            wrData,
    output memPkg::byteT            rdData
);

    localparam int Depth = 2 ** RamAddrWidth;

    memPkg::byteT mem [Depth];

    // read returns the old byte on a same-cycle write
    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= wrData;
        end
        rdData <= mem[addr];
    end

endmodule

/* rtl/fetchUnit.sv */
`timescale 1ns/100ps

module fetchUnit (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         redirect,
    input  memPkg::addrT redirectPc,
    input  logic         hitValid,
    input  memPkg::wordT hitInst,
    output logic         fetchReq,
    output memPkg::addrT fetchPc,
    output logic         instValid,
    output memPkg::addrT instPc,
    output memPkg::wordT inst
);

    memPkg::addrT pc;
    logic         running;
    logic         instValidQ;

    // request stays up with the current PC until the cache answers
    assign fetchReq = running;
    assign fetchPc = pc;
    assign instValid = instValidQ && rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            running <= 1'b0;
            instValidQ <= 1'b0;
        end else if (rdy) begin
            instValidQ <= 1'b0;
            if (redirect) begin
                // any answer arriving now belongs to the old path
                pc <= redirectPc;
                running <= 1'b1;
            end else if (running && hitValid) begin
                instValidQ <= 1'b1;
                pc <= pc + 32'd4;
            end
        end
    end

    // output stream registers
    always_ff @(posedge clk) begin
        if (rdy && running && hitValid && !redirect) begin
            instPc <= pc;
            inst <= hitInst;
        end
    end

endmodule

/* rtl/memSubsystem.sv */
`timescale 1ns/100ps

module memSubsystem #(
    parameter int RamAddrWidth = 12,
    parameter int CacheIndexWidth = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         redirect,
    input  memPkg::addrT redirectPc,
    output logic         instValid,
    output memPkg::addrT instPc,
    output memPkg::wordT inst,
    input  logic         lsEn,
    input  logic         lsWrite,
    input  memPkg::addrT lsAddr,
    input  memPkg::lenT  lsLen,
    input  memPkg::wordT storeData,
    output logic         lsDone,
    output memPkg::wordT ldData
);

    // fetch unit to cache
    logic                    fetchReq;
    memPkg::addrT            fetchPc;
    logic                    hitValid;
    memPkg::wordT            hitInst;

    // cache to controller
    logic                    fetchEn;
    memPkg::addrT            fetchAddr;
    logic                    instOutEn;
    memPkg::wordT            fillInst;
    memPkg::addrT            fillAddr;

    // controller to RAM
    logic                    ramWrite;
    logic [RamAddrWidth-1:0] ramAddr;
    memPkg::byteT            ramWrData;
    memPkg::byteT            ramRdData;

    fetchUnit fetch (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .hitValid  (hitValid),
        .hitInst   (hitInst),
        .fetchReq  (fetchReq),
        .fetchPc   (fetchPc),
        .instValid (instValid),
        .instPc    (instPc),
        .inst      (inst)
    );

    instCache #(
        .CacheIndexWidth(CacheIndexWidth)
    ) cache (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .redirect (redirect),
        .fetchReq (fetchReq),
        .fetchPc  (fetchPc),
        .hitValid (hitValid),
        .hitInst  (hitInst),
        .fetchEn  (fetchEn),
        .fetchAddr(fetchAddr),
        .instOutEn(instOutEn),
        .fillInst (fillInst),
        .fillAddr (fillAddr)
    );

    memCtrl #(
        .RamAddrWidth(RamAddrWidth)
    ) ctrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .fetchEn  (fetchEn),
        .fetchAddr(fetchAddr),
        .misTaken (redirect),
        .instOutEn(instOutEn),
        .inst     (fillInst),
        .addAddr  (fillAddr),
        .lsEn     (lsEn),
        .lsWrite  (lsWrite),
        .lsAddr   (lsAddr),
        .lsLen    (lsLen),
        .storeData(storeData),
        .lsDone   (lsDone),
        .ldData   (ldData),
        .ramWrite (ramWrite),
        .ramAddr  (ramAddr),
        .ramWrData(ramWrData),
        .ramRdData(ramRdData)
    );

    byteRam #(
        .RamAddrWidth(RamAddrWidth)
    ) ram (
        .clk   (clk),
        .write (ramWrite),
        .addr  (ramAddr),
        .wrData(ramWrData),
        .rdData(ramRdData)
    );

endmodule

/* sim/memSubsystem_assert.sv */
`timescale 1ns/100ps

module memSubsystem_assert (
    input logic         clk,
    input logic         rst,
    input logic         rdy,
    input logic         instValid,
    input logic         lsDone,
    input memPkg::wordT inst
);

    // one done pulse per request
    lsDoneSingle: assert property (@(posedge clk) disable iff (rst) lsDone |=> !lsDone)
        else $error("lsDone high on two cycles in a row");

    resetQuiet: assert property (@(posedge clk) rst |=> !instValid && !lsDone)
        else $error("strobe high in the cycle after reset");

    stallQuiet: assert property (@(posedge clk) disable iff (rst) !rdy |-> !instValid && !lsDone)
        else $error("strobe high while rdy is low");

    instKnown: assert property (@(posedge clk) disable iff (rst) instValid |-> !$isunknown(inst))
        else $error("inst has unknown bits while instValid is high");

endmodule

bind memSubsystem memSubsystem_assert checks (
    .clk      (clk),
    .rst      (rst),
    .rdy      (rdy),
    .instValid(instValid),
    .lsDone   (lsDone),
    .inst     (inst)
);

/* sim/memSubsystem_tb.sv */
`timescale 1ns/100ps

module memSubsystem_tb;

    localparam int RamAddrWidth = 12;
    localparam int CacheIndexWidth = 4;
    localparam int RamBytes = 2 ** RamAddrWidth;
    localparam int Timeout = 2000;
    localparam memPkg::addrT ProgBase = 32'h0000_0400;
    // small enough to stay in the cache for a second pass
    localparam int ProgWords = 12;

    logic         clk;
    logic         rst;
    logic         rdy;
    logic         redirect;
    memPkg::addrT redirectPc;
    logic         instValid;
    memPkg::addrT instPc;
    memPkg::wordT inst;
    logic         lsEn;
    logic         lsWrite;
    memPkg::addrT lsAddr;
    memPkg::lenT  lsLen;
    memPkg::wordT storeData;
    logic         lsDone;
    memPkg::wordT ldData;

    // reference copy of the RAM
    memPkg::byteT model [RamBytes];
    int           errors;
    int           instCount;
    int           loadCount;
    memPkg::addrT expPc;
    memPkg::addrT lastPc;

    tbClock clock (
        .clk(clk)
    );

    memSubsystem #(
        .RamAddrWidth   (RamAddrWidth),
        .CacheIndexWidth(CacheIndexWidth)
    ) UUT (
        .*
    );

    task automatic mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic timedOut(input string what);
        errors++;
        $display("Timed out waiting for %s at %0t", what, $time);
    endtask

    // every bit of the RAM address reaches the byte
    function automatic memPkg::byteT fillByte(memPkg::addrT a);
        return a[7:0] ^ {a[3:0], a[11:8]} ^ 8'h5a;
    endfunction

    // little-endian read, upper bytes zero
    function automatic memPkg::wordT modelRead(memPkg::addrT a, memPkg::lenT len);
        memPkg::wordT            w;
        logic [RamAddrWidth-1:0] idx;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            idx = a[RamAddrWidth-1:0] + RamAddrWidth'(i);
            w[i*8 +: 8] = model[idx];
        end
        return w;
    endfunction

    function automatic void modelWrite(memPkg::addrT a, memPkg::lenT len, memPkg::wordT data);
        logic [RamAddrWidth-1:0] idx;
        for (int i = 0; i < int'(len); i++) begin
            idx = a[RamAddrWidth-1:0] + RamAddrWidth'(i);
            model[idx] = data[i*8 +: 8];
        end
    endfunction

    // instruction stream and stall checks
    always @(posedge clk) begin
        if (!rst) begin
            assert (rdy || (!instValid && !lsDone))
                else mismatch("strobe high while rdy is low");
            if (instValid) begin
                assert (instPc == expPc)
                    else mismatch($sformatf("instPc %h, expected %h", instPc, expPc));
                assert (inst == modelRead(instPc, memPkg::WordLen))
                    else mismatch($sformatf("inst %h at %h, expected %h", inst, instPc,
                        modelRead(instPc, memPkg::WordLen)));
                lastPc = instPc;
                instCount++;
                expPc = expPc + 32'd4;
            end
            if (redirect && rdy) begin
                expPc = redirectPc;
            end
        end
    end

    // lsEn stays up until a cycle with rdy high takes it
    task automatic lsAccess(input logic write, input memPkg::addrT addr,
                            input memPkg::lenT len, input memPkg::wordT data);
        memPkg::wordT expected;
        bit           taken;
        bit           done;
        expected = modelRead(addr, len);
        taken = 1'b0;
        done = 1'b0;
        @(negedge clk);
        lsEn = 1'b1;
        lsWrite = write;
        lsAddr = addr;
        lsLen = len;
        storeData = data;
        for (int t = 0; t < Timeout && !taken; t++) begin
            @(posedge clk);
            taken = rdy;
        end
        @(negedge clk);
        lsEn = 1'b0;
        for (int t = 0; t < Timeout && !done; t++) begin
            @(posedge clk);
            done = lsDone;
        end
        if (!done) begin
            timedOut($sformatf("lsDone of access at %h", addr));
        end else if (write) begin
            modelWrite(addr, len, data);
        end else begin
            loadCount++;
            assert (ldData == expected)
                else mismatch($sformatf("ldData %h at %h len %0d, expected %h",
                    ldData, addr, len, expected));
        end
    endtask

    task automatic randomLoad();
        memPkg::lenT  len;
        memPkg::addrT a;
        len = 3'd1 << $urandom_range(2, 0);
        a = $urandom_range(RamBytes - 1, 0) & ~(32'(len) - 32'd1);
        lsAccess(1'b0, a, len, '0);
    endtask

    task automatic redirectTo(input memPkg::addrT pc);
        bit taken;
        taken = 1'b0;
        @(negedge clk);
        redirect = 1'b1;
        redirectPc = pc;
        for (int t = 0; t < Timeout && !taken; t++) begin
            @(posedge clk);
            taken = rdy;
        end
        @(negedge clk);
        redirect = 1'b0;
        if (!taken) begin
            timedOut("rdy to take the redirect");
        end
    endtask

    task automatic waitInstructions(input int target);
        int t;
        t = 0;
        while (instCount < target && t < Timeout) begin
            @(negedge clk);
            t++;
        end
        if (instCount < target) begin
            timedOut($sformatf("instruction %0d", target));
        end
    endtask

    task automatic stallRdy(input int cycles);
        int span;
        span = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (span > 0) begin
                span--;
            end else if ($urandom_range(3, 0) == 0) begin
                span = $urandom_range(6, 1);
            end
            rdy = (span == 0);
        end
        @(negedge clk);
        rdy = 1'b1;
    endtask

    task automatic testReset();
        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
            assert (!instValid && !lsDone)
                else mismatch("strobe high before any request");
        end
    endtask

    task automatic fillRam();
        memPkg::wordT w;
        for (int i = 0; i < RamBytes; i += 4) begin
            for (int b = 0; b < 4; b++) begin
                w[b*8 +: 8] = fillByte(32'(i + b));
            end
            lsAccess(1'b1, 32'(i), memPkg::WordLen, w);
        end
    endtask

    task automatic testStoreLoad();
        memPkg::addrT a;
        for (int n = 0; n < 8; n++) begin
            a = $urandom_range(RamBytes / 4 - 1, 0) << 2;
            lsAccess(1'b1, a, 3'd4, $urandom);
            lsAccess(1'b0, a, 3'd4, '0);
            lsAccess(1'b0, a + ($urandom_range(1, 0) << 1), 3'd2, '0);
            lsAccess(1'b0, a + $urandom_range(3, 0), 3'd1, '0);
        end
    endtask

    task automatic testFetchStream();
        int startCount;
        for (int i = 0; i < ProgWords; i++) begin
            lsAccess(1'b1, ProgBase + 32'(i * 4), memPkg::WordLen, $urandom);
        end
        redirectTo(ProgBase);
        startCount = instCount;
        waitInstructions(startCount + ProgWords);
        assert (lastPc == ProgBase + 32'(4 * (ProgWords - 1)))
            else mismatch($sformatf("last PC %h after the program", lastPc));
    endtask

    // second pass hits in the cache while loads compete for the RAM
    task automatic testCacheReuse();
        int startCount;
        redirectTo(ProgBase);
        startCount = instCount;
        repeat (10) randomLoad();
        waitInstructions(startCount + ProgWords);
    endtask

    task automatic testRedirectMidMiss();
        int           startCount;
        memPkg::addrT target;
        for (int n = 0; n < 4; n++) begin
            redirectTo(32'h0000_0800 + 32'(n * 64));
            repeat ($urandom_range(4, 1)) @(negedge clk);
            target = 32'h0000_0c00 + 32'(n * 128);
            redirectTo(target);
            startCount = instCount;
            waitInstructions(startCount + 1);
            assert (lastPc == target)
                else mismatch($sformatf("first PC %h after redirect, expected %h", lastPc, target));
            waitInstructions(startCount + 4);
        end
    endtask

    task automatic testStall();
        int startCount;
        redirectTo(ProgBase);
        startCount = instCount;
        fork
            stallRdy(400);
            begin
                repeat (8) randomLoad();
                waitInstructions(startCount + 2 * ProgWords);
            end
        join
    endtask

    initial begin
        errors = 0;
        instCount = 0;
        loadCount = 0;
        expPc = '0;
        lastPc = '0;
        void'($urandom(42490));
        rst = 1'b1;
        rdy = 1'b1;
        redirect = 1'b0;
        redirectPc = '0;
        lsEn = 1'b0;
        lsWrite = 1'b0;
        lsAddr = '0;
        lsLen = 3'd4;
        storeData = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        testReset();
        fillRam();
        testStoreLoad();
        testFetchStream();
        testCacheReuse();
        testRedirectMidMiss();
        testStall();
        repeat (4) @(negedge clk);
        $display("Instructions checked: %0d, loads checked: %0d, errors: %0d",
            instCount, loadCount, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sim/tbClock.sv */
`timescale 1ns/100ps

module tbClock #(
    parameter int HalfPeriod = 2
) (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
    end

    always #(HalfPeriod) clk = ~clk;

endmodule

/* src.f */
common/memPkg.sv
rtl/byteRam.sv
rtl/fetchUnit.sv
icache/instCache.sv
memCtrl/memCtrl.sv
rtl/memSubsystem.sv
sim/tbClock.sv
sim/memSubsystem_assert.sv
sim/memSubsystem_tb.sv
